// File: all.f
+incdir+hw
hw/lsu_pkg.sv
hw/load_store_unit.sv
hw/data_memory.sv
hw/mem_stage.sv
hw/lsu_subsystem_top.sv
verification/tb_clock_gen.sv
verification/lsu_subsystem_tb.sv

// File: hw/data_memory.sv
// --------------------
// Byte strobed data memory on the load store bus
// Every transaction stalls for a fixed number of cycles, then completes
// Addresses past the end of the array return a bus error
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module data_memory
    import lsu_pkg::*;
(
    input  logic   g_clk,
    input  logic   g_resetn,

    input  logic   dmem_cen,    // Chip enable
    input  logic   dmem_wen,    // Write enable
    input  strb_t  dmem_strb,   // Byte write strobes
    input  xword_t dmem_addr,   // Word aligned address
    input  xword_t dmem_wdata,  // Store data
    output logic   dmem_stall,  // Transaction still running
    output logic   dmem_error,  // Out of range, completion cycle only
    output xword_t dmem_rdata   // Registered read word
);

    localparam int unsigned WORDS = `LSU_MEM_BYTES / 4;
    localparam int unsigned IDX_W = $clog2(WORDS);
    localparam int unsigned CNT_W = $clog2(`LSU_MEM_WAIT + 1);

    localparam xword_t           MEM_LIMIT = xword_t'(`LSU_MEM_BYTES);
    localparam logic [CNT_W-1:0] CNT_LAST  = CNT_W'(`LSU_MEM_WAIT);

    xword_t           mem [WORDS];
    logic [CNT_W-1:0] wait_cnt;
    logic [IDX_W-1:0] word_idx;
    logic             in_range;
    logic             txn_done;

    assign word_idx = dmem_addr[IDX_W+1:2];
    assign in_range = dmem_addr < MEM_LIMIT;

    // --------------------
    // Wait states

    assign dmem_stall = dmem_cen && (wait_cnt != CNT_LAST);
    assign txn_done   = dmem_cen && !dmem_stall;
    assign dmem_error = txn_done && !in_range;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            wait_cnt <= '0;
        end else if (!dmem_cen || txn_done) begin
            wait_cnt <= '0;              // Ready for the next transaction
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // --------------------
    // Storage

    // Read word is sampled while stalled and kept until the next access
    always_ff @(posedge g_clk) begin
        if (dmem_stall) begin
            dmem_rdata <= in_range ? mem[word_idx] : '0;
        end
    end

    // Writes land in the completion cycle, out of range ones are dropped
    always_ff @(posedge g_clk) begin
        if (txn_done && dmem_wen && in_range) begin
            for (int i = 0; i < $bits(strb_t); i++) begin
                if (dmem_strb[i]) begin
                    mem[word_idx][8*i +: 8] <= dmem_wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/load_store_unit.sv
// --------------------
// Load store unit of the memory stage
// Maps byte, halfword and word accesses onto the aligned data bus,
// extends load data and flags misaligned addresses and bus errors
// --------------------
`timescale 1ns/1ps
`default_nettype none

module load_store_unit
    import lsu_pkg::*;
(
    input  logic     g_clk,
    input  logic     g_resetn,

    input  logic     lsu_valid,     // Instruction held by the stage
    input  lsu_req_t lsu_req,       // Held instruction fields
    input  logic     pipe_prog,     // Stage retires this cycle

    output logic     lsu_ready,     // Access complete
    output logic     lsu_a_error,   // Misaligned address
    output logic     lsu_b_error,   // Bus error
    output xword_t   lsu_rdata,     // Extended load data

    output logic     dmem_cen,      // Chip enable
    output logic     dmem_wen,      // Write enable
    output strb_t    dmem_strb,     // Byte write strobes
    output xword_t   dmem_addr,     // Word aligned address
    output xword_t   dmem_wdata,    // Lane placed store data
    input  logic     dmem_stall,    // Memory not done yet
    input  logic     dmem_error,    // Bus error on completion
    input  xword_t   dmem_rdata     // Read word
);

    logic       txn_done;
    logic       txn_err;
    logic       finished;
    logic       finished_nxt;
    logic       b_err_held;
    logic       b_err_held_nxt;
    logic [1:0] offset;
    xword_t     lane_data;
    logic       byte_sign;
    logic       half_sign;

    // --------------------
    // Completion tracking

    assign txn_done = dmem_cen && !dmem_stall;
    assign txn_err  = txn_done && dmem_error;

    // Done flag lives until the stage retires
    assign finished_nxt   = (finished || (lsu_valid && txn_done)) && !pipe_prog;
    assign b_err_held_nxt = (b_err_held || txn_err) && !pipe_prog;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            finished   <= 1'b0;
            b_err_held <= 1'b0;
        end else begin
            finished   <= finished_nxt;
            b_err_held <= b_err_held_nxt;  // Error survives a held result
        end
    end

    assign lsu_ready   = txn_done || finished;
    assign lsu_b_error = txn_err || b_err_held;

    // --------------------
    // Alignment check

    assign offset = lsu_req.addr[1:0];

    assign lsu_a_error = (lsu_req.half_op && offset[0]) ||
                         (lsu_req.word_op && (offset != 2'b00));

    // --------------------
    // Bus request

    // No repeat access once done, none at all when misaligned
    assign dmem_cen  = lsu_valid && !finished && !lsu_a_error;
    assign dmem_wen  = lsu_req.store;
    assign dmem_addr = lsu_req.addr & ~xword_t'(3);

    // Narrow data is copied to every lane, strobes pick the right one
    always_comb begin
        if (lsu_req.byte_op) begin
            dmem_wdata = {4{lsu_req.wdata[7:0]}};
            dmem_strb  = strb_t'(4'b0001) << offset;
        end else if (lsu_req.half_op) begin
            dmem_wdata = {2{lsu_req.wdata[15:0]}};
            dmem_strb  = strb_t'(4'b0011) << {offset[1], 1'b0};
        end else begin
            dmem_wdata = lsu_req.wdata;
            dmem_strb  = '1;
        end
    end

    // --------------------
    // Load data

    assign lane_data = dmem_rdata >> {offset, 3'b000};  // Addressed lane to bit 0
    assign byte_sign = lsu_req.signed_op && lane_data[7];
    assign half_sign = lsu_req.signed_op && lane_data[15];

    always_comb begin
        if (!lsu_req.load) begin
            lsu_rdata = '0;
        end else if (lsu_req.byte_op) begin
            lsu_rdata = {{24{byte_sign}}, lane_data[7:0]};
        end else if (lsu_req.half_op) begin
            lsu_rdata = {{16{half_sign}}, lane_data[15:0]};
        end else begin
            lsu_rdata = dmem_rdata;
        end
    end

endmodule

`default_nettype wire

// File: hw/lsu_pkg.sv
// --------------------
// Types shared by the memory stage, the load store unit and the memory
// Import with lsu_pkg::* in the module header
// --------------------
`default_nettype none

`include "lsu_settings.svh"

package lsu_pkg;

    // --------------------
    // Plain vectors

    typedef logic [`LSU_XLEN-1:0]   xword_t;    // Data or address word
    typedef logic [`LSU_XLEN/8-1:0] strb_t;     // One bit per byte lane

    // --------------------
    // One memory instruction as seen by the stage

    typedef struct packed {
        xword_t addr;       // Byte address
        xword_t wdata;      // Store data, low bits used for narrow ops
        logic   load;       // Load instruction
        logic   store;      // Store instruction
        logic   byte_op;    // Byte width
        logic   half_op;    // Halfword width
        logic   word_op;    // Word width
        logic   signed_op;  // Sign extend narrow loads
    } lsu_req_t;

    // --------------------
    // Result of one instruction

    typedef struct packed {
        xword_t rdata;      // Extended load data
        logic   a_error;    // Misaligned address
        logic   b_error;    // Bus error
    } lsu_rsp_t;

endpackage

`default_nettype wire

// File: hw/lsu_settings.svh
// --------------------
// Build settings of the memory stage
// Included by the package and by the data memory
// --------------------
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Data and address width, fixed by the bus
`define LSU_XLEN 32

// Size of the data memory in bytes, any power of two
`define LSU_MEM_BYTES 1024

// Stall cycles per bus transaction, 1 or more
`define LSU_MEM_WAIT 2

`endif

// File: hw/lsu_subsystem_top.sv
// --------------------
// Memory stage subsystem
// Stage controller and load store unit with the data memory on its bus
// --------------------
`timescale 1ns/1ps
`default_nettype none

module lsu_subsystem_top
    import lsu_pkg::*;
(
    input  logic     g_clk,
    input  logic     g_resetn,
    input  logic     req_valid,     // Accepted while busy is low
    input  lsu_req_t req,
    input  logic     result_hold,   // Delays retirement
    output logic     busy,
    output logic     rsp_valid,     // One cycle per instruction
    output lsu_rsp_t rsp
);

    // Stage to unit
    logic     lsu_valid;
    lsu_req_t lsu_req;
    logic     pipe_prog;
    logic     lsu_ready;
    logic     lsu_a_error;
    logic     lsu_b_error;
    xword_t   lsu_rdata;

    // Data bus
    logic     dmem_cen;
    logic     dmem_wen;
    strb_t    dmem_strb;
    xword_t   dmem_addr;
    xword_t   dmem_wdata;
    logic     dmem_stall;
    logic     dmem_error;
    xword_t   dmem_rdata;

    mem_stage mem_stage_i (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .req_valid   (req_valid),
        .req         (req),
        .result_hold (result_hold),
        .busy        (busy),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .lsu_valid   (lsu_valid),
        .lsu_req     (lsu_req),
        .pipe_prog   (pipe_prog),
        .lsu_ready   (lsu_ready),
        .lsu_a_error (lsu_a_error),
        .lsu_b_error (lsu_b_error),
        .lsu_rdata   (lsu_rdata)
    );

    load_store_unit load_store_unit_i (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .lsu_valid   (lsu_valid),
        .lsu_req     (lsu_req),
        .pipe_prog   (pipe_prog),
        .lsu_ready   (lsu_ready),
        .lsu_a_error (lsu_a_error),
        .lsu_b_error (lsu_b_error),
        .lsu_rdata   (lsu_rdata),
        .dmem_cen    (dmem_cen),
        .dmem_wen    (dmem_wen),
        .dmem_strb   (dmem_strb),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .dmem_stall  (dmem_stall),
        .dmem_error  (dmem_error),
        .dmem_rdata  (dmem_rdata)
    );

    data_memory data_memory_i (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .dmem_cen   (dmem_cen),
        .dmem_wen   (dmem_wen),
        .dmem_strb  (dmem_strb),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_stall (dmem_stall),
        .dmem_error (dmem_error),
        .dmem_rdata (dmem_rdata)
    );

endmodule

`default_nettype wire

// File: hw/mem_stage.sv
// --------------------
// Memory stage controller
// Holds one instruction for the load store unit, retires it when
// the access is done and the result is not held, then reports it
// --------------------
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import lsu_pkg::*;
(
    input  logic     g_clk,
    input  logic     g_resetn,

    input  logic     req_valid,     // New instruction strobe
    input  lsu_req_t req,           // New instruction
    input  logic     result_hold,   // Back-pressure on retirement
    output logic     busy,          // Instruction in flight
    output logic     rsp_valid,     // One cycle result pulse
    output lsu_rsp_t rsp,           // Result, kept until next pulse

    output logic     lsu_valid,     // Instruction held
    output lsu_req_t lsu_req,       // Held instruction
    output logic     pipe_prog,     // Retire this cycle
    input  logic     lsu_ready,
    input  logic     lsu_a_error,
    input  logic     lsu_b_error,
    input  xword_t   lsu_rdata
);

    logic     held;
    logic     accept;
    logic     retire;
    lsu_req_t req_q;

    assign accept = req_valid && !held;     // Strobes while busy are dropped
    assign retire = held && (lsu_ready || lsu_a_error) && !result_hold;

    // --------------------
    // Control

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            held      <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= retire;
            if (accept) begin
                held <= 1'b1;
            end else if (retire) begin
                held <= 1'b0;
            end
        end
    end

    // --------------------
    // Instruction and result registers

    always_ff @(posedge g_clk) begin
        if (accept) begin
            req_q <= req;
        end
        if (retire) begin
            rsp.rdata   <= lsu_rdata;
            rsp.a_error <= lsu_a_error;
            rsp.b_error <= lsu_b_error;
        end
    end

    assign busy      = held;
    assign lsu_valid = held;
    assign lsu_req   = req_q;
    assign pipe_prog = retire;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -f all.f --top-module lsu_subsystem_tb -o lsu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/lsu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    exit 1
fi

exit 0

// File: verification/lsu_subsystem_tb.sv
// --------------------
// Testbench of the memory stage subsystem
// Runs a table of loads and stores and checks every response
// against a byte reference memory, flags, pulse count and latency
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_subsystem_tb
    import lsu_pkg::*;
();

    localparam int WAIT         = `LSU_MEM_WAIT;
    localparam int MAX_HOLD     = 5;
    localparam int RESET_CYCLES = 16;

    localparam int W_BYTE = 0;
    localparam int W_HALF = 1;
    localparam int W_WORD = 2;

    localparam int E_NONE  = 0;
    localparam int E_ALIGN = 1;
    localparam int E_BUS   = 2;

    typedef struct {
        string       name;
        bit          store;
        int          width;
        bit          sgn;
        logic [31:0] addr;
        logic [31:0] data;
        int          hold;
        int          err;
    } row_t;

    logic     g_clk;
    logic     g_resetn;
    logic     req_valid;
    lsu_req_t req;
    logic     result_hold;
    logic     busy;
    logic     rsp_valid;
    lsu_rsp_t rsp;

    row_t        rows[$];
    logic [7:0]  ref_mem [`LSU_MEM_BYTES];
    logic [31:0] lfsr_state;
    int          value_errs;
    int          proto_errs;
    int          cycles;

    tb_clock_gen tb_clock_gen_i (
        .g_clk    (g_clk),
        .g_resetn (g_resetn)
    );

    lsu_subsystem_top lsu_subsystem_top_i (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .req_valid   (req_valid),
        .req         (req),
        .result_hold (result_hold),
        .busy        (busy),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp)
    );

    // --------------------
    // Random data and the table

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic add_row(input string name, input bit store, input int width,
                           input bit sgn, input logic [31:0] addr,
                           input logic [31:0] data, input int hold, input int err);
        row_t r;
        r.name  = name;
        r.store = store;
        r.width = width;
        r.sgn   = sgn;
        r.addr  = addr;
        r.data  = data;
        r.hold  = hold;
        r.err   = err;
        rows.push_back(r);
    endtask

    // --------------------
    // Reference memory

    function automatic logic [31:0] load_value(input logic [31:0] addr, input int width,
                                               input bit sgn);
        int          a;
        logic [7:0]  b;
        logic [15:0] h;
        a = int'(addr);
        b = ref_mem[a];
        h = {ref_mem[a+1], ref_mem[a]};
        if (width == W_BYTE) begin
            return {{24{sgn && b[7]}}, b};
        end else if (width == W_HALF) begin
            return {{16{sgn && h[15]}}, h};
        end
        return {ref_mem[a+3], ref_mem[a+2], h};
    endfunction

    task automatic update_ref(input row_t r);
        int a;
        a = int'(r.addr);
        for (int i = 0; i < (1 << r.width); i++) begin
            ref_mem[a+i] = r.data[8*i +: 8];
        end
    endtask

    // --------------------
    // One row: drive, wait for the pulse, check

    task automatic run_row(input row_t r);
        lsu_req_t    q;
        lsu_rsp_t    got;
        logic [31:0] exp_rdata;
        int          cyc;
        int          pulses;
        int          lat;
        int          exp_lat;
        q           = '0;
        q.addr      = r.addr;
        q.wdata     = r.data;
        q.load      = !r.store;
        q.store     = r.store;
        q.byte_op   = (r.width == W_BYTE);
        q.half_op   = (r.width == W_HALF);
        q.word_op   = (r.width == W_WORD);
        q.signed_op = r.sgn;
        while (busy) @(negedge g_clk);
        @(posedge g_clk);
        req_valid   <= 1'b1;
        req         <= q;
        result_hold <= (r.hold > 0);
        @(posedge g_clk);                   // Accept edge
        req_valid <= 1'b0;
        cyc    = 0;
        pulses = 0;
        lat    = 0;
        got    = '0;
        while (pulses == 0) begin
            @(negedge g_clk);
            cyc++;
            if (rsp_valid) begin
                pulses++;
                lat = cyc;
                got = rsp;
                assert (!busy) else begin
                    proto_errs++;
                    $display("%s: busy still high with the response", r.name);
                end
            end else begin
                @(posedge g_clk);
                if (cyc >= r.hold) begin
                    result_hold <= 1'b0;
                end
            end
        end
        repeat (2) begin                    // No second pulse
            @(negedge g_clk);
            if (rsp_valid) begin
                pulses++;
            end
        end
        assert (pulses == 1) else begin
            proto_errs++;
            $display("%s: got %0d response pulses instead of one", r.name, pulses);
        end

        exp_rdata = '0;
        if (r.err == E_NONE && !r.store) begin
            exp_rdata = load_value(r.addr, r.width, r.sgn);
        end
        if (r.err == E_NONE && r.store) begin
            update_ref(r);
        end
        assert (got.a_error == (r.err == E_ALIGN)) else begin
            value_errs++;
            $display("error %s a_error: expected %0d actual %0d",
                     r.name, (r.err == E_ALIGN), got.a_error);
        end
        assert (got.b_error == (r.err == E_BUS)) else begin
            value_errs++;
            $display("error %s b_error: expected %0d actual %0d",
                     r.name, (r.err == E_BUS), got.b_error);
        end
        // Misaligned loads carry no defined data
        if (r.err != E_ALIGN) begin
            assert (got.rdata == exp_rdata) else begin
                value_errs++;
                $display("error %s rdata: expected %h actual %h", r.name, exp_rdata, got.rdata);
            end
        end
        exp_lat = (r.err == E_ALIGN) ? 2 : WAIT + 2;
        if (r.hold + 2 > exp_lat) begin
            exp_lat = r.hold + 2;           // Retires right after the hold drops
        end
        assert (lat == exp_lat) else begin
            proto_errs++;
            $display("%s: response came %0d cycles after accept, not %0d",
                     r.name, lat, exp_lat);
        end
    endtask

    // --------------------
    // Timeout

    always @(posedge g_clk) begin
        cycles <= cycles + 1;
        if (cycles >= rows.size() * (WAIT + MAX_HOLD + 6) + RESET_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // --------------------
    // Main sequence

    initial begin
        req_valid   = 1'b0;
        req         = '0;
        result_hold = 1'b0;
        value_errs  = 0;
        proto_errs  = 0;
        cycles      = 0;
        lfsr_state  = 32'd89866;

        add_row("sw_word",      1, W_WORD, 0, 32'h010, rand_bits(32), 0, E_NONE);
        add_row("lw_word",      0, W_WORD, 0, 32'h010, 32'h0, 0, E_NONE);
        add_row("sw_base_b",    1, W_WORD, 0, 32'h020, rand_bits(32), 0, E_NONE);
        add_row("sb_off0",      1, W_BYTE, 0, 32'h020, rand_bits(8), 0, E_NONE);
        add_row("sb_off1",      1, W_BYTE, 0, 32'h021, rand_bits(8), 0, E_NONE);
        add_row("sb_off2",      1, W_BYTE, 0, 32'h022, rand_bits(8), 0, E_NONE);
        add_row("sb_off3",      1, W_BYTE, 0, 32'h023, rand_bits(8), 0, E_NONE);
        add_row("lw_merge_b",   0, W_WORD, 0, 32'h020, 32'h0, 0, E_NONE);
        add_row("sw_base_h",    1, W_WORD, 0, 32'h024, rand_bits(32), 0, E_NONE);
        add_row("sh_off0",      1, W_HALF, 0, 32'h024, rand_bits(16), 0, E_NONE);
        add_row("sh_off2",      1, W_HALF, 0, 32'h026, rand_bits(16), 0, E_NONE);
        add_row("lw_merge_h",   0, W_WORD, 0, 32'h024, 32'h0, 0, E_NONE);
        add_row("sw_signs",     1, W_WORD, 0, 32'h030, 32'h8001_7ff0, 0, E_NONE);
        add_row("lb_0",         0, W_BYTE, 1, 32'h030, 32'h0, 0, E_NONE);
        add_row("lbu_0",        0, W_BYTE, 0, 32'h030, 32'h0, 0, E_NONE);
        add_row("lb_1",         0, W_BYTE, 1, 32'h031, 32'h0, 0, E_NONE);
        add_row("lbu_1",        0, W_BYTE, 0, 32'h031, 32'h0, 0, E_NONE);
        add_row("lb_2",         0, W_BYTE, 1, 32'h032, 32'h0, 0, E_NONE);
        add_row("lbu_2",        0, W_BYTE, 0, 32'h032, 32'h0, 0, E_NONE);
        add_row("lb_3",         0, W_BYTE, 1, 32'h033, 32'h0, 0, E_NONE);
        add_row("lbu_3",        0, W_BYTE, 0, 32'h033, 32'h0, 0, E_NONE);
        add_row("lh_0",         0, W_HALF, 1, 32'h030, 32'h0, 0, E_NONE);
        add_row("lhu_0",        0, W_HALF, 0, 32'h030, 32'h0, 0, E_NONE);
        add_row("lh_2",         0, W_HALF, 1, 32'h032, 32'h0, 0, E_NONE);
        add_row("lhu_2",        0, W_HALF, 0, 32'h032, 32'h0, 0, E_NONE);
        add_row("lh_odd",       0, W_HALF, 1, 32'h031, 32'h0, 0, E_ALIGN);
        add_row("sh_odd",       1, W_HALF, 0, 32'h033, rand_bits(16), 0, E_ALIGN);
        add_row("sw_mis",       1, W_WORD, 0, 32'h012, rand_bits(32), 0, E_ALIGN);
        add_row("lw_mis",       0, W_WORD, 0, 32'h011, 32'h0, 0, E_ALIGN);
        add_row("lw_after_mis", 0, W_WORD, 0, 32'h010, 32'h0, 0, E_NONE);
        add_row("lw_signs_chk", 0, W_WORD, 0, 32'h030, 32'h0, 0, E_NONE);
        add_row("lw_oob",       0, W_WORD, 0, 32'h400, 32'h0, 0, E_BUS);
        add_row("sw_oob",       1, W_WORD, 0, 32'h410, rand_bits(32), 0, E_BUS);
        add_row("lb_oob",       0, W_BYTE, 1, 32'h7fd, 32'h0, 3, E_BUS);
        add_row("lw_after_oob", 0, W_WORD, 0, 32'h010, 32'h0, 0, E_NONE);
        add_row("sw_hold",      1, W_WORD, 0, 32'h040, rand_bits(32),
                int'(rand_bits(2)) + 1, E_NONE);
        add_row("lw_hold",      0, W_WORD, 0, 32'h040, 32'h0, 4, E_NONE);
        add_row("sb_hold",      1, W_BYTE, 0, 32'h041, rand_bits(8), 3, E_NONE);
        add_row("lw_after_hold", 0, W_WORD, 0, 32'h040, 32'h0, 0, E_NONE);
        add_row("lhu_hold",     0, W_HALF, 0, 32'h042, 32'h0,
                int'(rand_bits(2)) + 1, E_NONE);
        add_row("lw_hold_long", 0, W_WORD, 0, 32'h024, 32'h0, MAX_HOLD, E_NONE);

        @(posedge g_clk);
        while (!g_resetn) @(posedge g_clk);
        foreach (rows[i]) begin
            run_row(rows[i]);
        end

        $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
// --------------------
// Clock and reset for the testbench
// 40 ns clock, reset held low for 16 cycles
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic g_clk,
    output logic g_resetn
);

    initial begin
        g_clk = 1'b0;
        forever #20 g_clk = ~g_clk;     // Half period
    end

    initial begin
        g_resetn = 1'b0;
        repeat (16) @(posedge g_clk);
        g_resetn <= 1'b1;
    end

endmodule

`default_nettype wire
